// File: design/ooo_macros.svh
`ifndef OOO_MACROS_SVH
`define OOO_MACROS_SVH

// architectural registers, r0 reads as zero and keeps its mapping
`define OOO_ARCH_REGS 8

// physical register file, twice the architectural count
`define OOO_PHYS_REGS 16

// reorder buffer entries
`define OOO_ROB_DEPTH 8

// multiply pipe depth in cycles
`define OOO_MUL_LAT 3

// datapath width
`define OOO_XLEN 32

`endif

// File: design/ooo_pkg.sv
`include "ooo_macros.svh"

package ooo_pkg;

    // supported operations, immediate form only for add
    typedef enum logic [2:0] {
        OP_ADD  = 3'd0,
        OP_SUB  = 3'd1,
        OP_XOR  = 3'd2,
        OP_ADDI = 3'd3,
        OP_MUL  = 3'd4
    } op_e;

    typedef logic [$clog2(`OOO_ARCH_REGS)-1:0] arch_reg_t; // 3 bits
    typedef logic [$clog2(`OOO_PHYS_REGS)-1:0] phys_reg_t; // 4 bits
    typedef logic [$clog2(`OOO_ROB_DEPTH)-1:0] rob_tag_t;  // 3 bits
    typedef logic [`OOO_XLEN-1:0]              xlen_t;

    // instruction as it enters the slice
    typedef struct packed {
        logic [31:0] pc;
        op_e         op;
        arch_reg_t   rd;
        arch_reg_t   rs1;
        arch_reg_t   rs2;
        logic [31:0] imm;
    } instr_t;

    // after rename, everything in physical space
    typedef struct packed {
        logic [31:0] pc;
        op_e         op;
        phys_reg_t   prd;
        phys_reg_t   prs1;
        phys_reg_t   prs2;
        logic [31:0] imm;
        rob_tag_t    tag;
        logic        wr;   // clear for rd == 0
    } renamed_t;

    // new rob entry
    typedef struct packed {
        logic [31:0] pc;
        arch_reg_t   rd;
        phys_reg_t   prd;
        phys_reg_t   old_prd; // released at retirement
        logic        wr;
    } rob_alloc_t;

    typedef struct packed {
        rob_tag_t tag;
        xlen_t    data;
    } complete_t;

    // retired instruction, one per commit slot
    typedef struct packed {
        logic [31:0] pc;
        arch_reg_t   rd;
        xlen_t       data;
        logic        wr;
    } commit_t;

    typedef struct packed {
        logic      valid;
        phys_reg_t preg;
    } free_t;

endpackage

// File: design/rename_stage.sv
`include "ooo_macros.svh"

module rename_stage import ooo_pkg::*; (
    input  logic        clk,
    input  logic        rstn,
    // instruction source
    input  logic        in_valid,
    output logic        in_ready,
    input  instr_t      in_instr,
    // towards issue
    output logic        ren_valid,
    input  logic        ren_ready,
    output renamed_t    ren_out,
    // rob allocation, same handshake as the input
    output logic        alloc_valid,
    output rob_alloc_t  alloc,
    input  rob_tag_t    rob_tail,
    input  logic        rob_full,
    // old mappings coming back from retirement
    input  free_t [1:0] free_in
);

    phys_reg_t                 map_q [`OOO_ARCH_REGS]; // arch -> phys
    logic [`OOO_PHYS_REGS-1:0] free_q;                 // bit set = register free
    logic                      run_q;                  // held low through reset
    phys_reg_t                 new_prd;
    logic                      wr_en;
    logic                      accept;
    renamed_t                  ren_next;

    // lowest free register, scan from the top so index 0 wins last
    always_comb begin
        new_prd = '0;
        for (int i = `OOO_PHYS_REGS - 1; i >= 0; i--) begin
            if (free_q[i]) begin
                new_prd = phys_reg_t'(i);
            end
        end
    end

    assign wr_en    = (in_instr.rd != '0); // r0 never renamed
    assign in_ready = run_q && ren_ready && !rob_full && (|free_q);
    assign accept   = in_valid && in_ready;

    // sources read through the map before this edge updates it
    always_comb begin
        ren_next.pc   = in_instr.pc;
        ren_next.op   = in_instr.op;
        ren_next.prd  = wr_en ? new_prd : '0;
        ren_next.prs1 = map_q[in_instr.rs1];
        ren_next.prs2 = map_q[in_instr.rs2];
        ren_next.imm  = in_instr.imm;
        ren_next.tag  = rob_tail;  // entry being allocated right now
        ren_next.wr   = wr_en;
    end

    assign alloc_valid = accept;

    always_comb begin
        alloc.pc      = in_instr.pc;
        alloc.rd      = in_instr.rd;
        alloc.prd     = ren_next.prd;
        alloc.old_prd = map_q[in_instr.rd]; // freed when this entry retires
        alloc.wr      = wr_en;
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            run_q     <= 1'b0;
            ren_valid <= 1'b0;
            for (int i = 0; i < `OOO_ARCH_REGS; i++) begin
                map_q[i] <= phys_reg_t'(i);  // identity map
            end
            for (int i = 0; i < `OOO_PHYS_REGS; i++) begin
                free_q[i] <= (i >= `OOO_ARCH_REGS);
            end
        end else begin
            run_q <= 1'b1;
            if (accept) begin
                ren_valid <= 1'b1;
            end else if (ren_ready) begin
                ren_valid <= 1'b0;
            end
            for (int k = 0; k < 2; k++) begin
                if (free_in[k].valid) begin
                    free_q[free_in[k].preg] <= 1'b1;
                end
            end
            if (accept && wr_en) begin
                free_q[new_prd]    <= 1'b0;
                map_q[in_instr.rd] <= new_prd;
            end
        end
    end

    // output payload, only loaded on acceptance
    always_ff @(posedge clk) begin
        if (accept) begin
            ren_out <= ren_next;
        end
    end

    // rob hands back each old mapping once, after its last reader is gone
    for (genvar k = 0; k < 2; k++) begin : g_free_chk
        a_no_double_free: assert property (@(posedge clk) disable iff (!rstn)
            free_in[k].valid |-> !free_q[free_in[k].preg])
            else $error("phys reg %0d freed twice", free_in[k].preg);
    end

endmodule

// File: design/issue_execute.sv
`include "ooo_macros.svh"

module issue_execute import ooo_pkg::*; (
    input  logic      clk,
    input  logic      rstn,
    // renamed instruction, issued straight from the rename register
    input  logic      ren_valid,
    output logic      ren_ready,
    input  renamed_t  ren_in,
    // completions, never stalled by the rob
    output logic      alu_done_valid,
    output complete_t alu_done,
    output logic      mul_done_valid,
    output complete_t mul_done
);

    // in-flight result plus where it lands in the prf
    typedef struct packed {
        logic      wr;
        phys_reg_t prd;
        complete_t done;
    } pipe_t;

    xlen_t                     prf_q [`OOO_PHYS_REGS];
    logic [`OOO_PHYS_REGS-1:0] ready_q;   // value present in prf
    logic                      alu_v_q;
    pipe_t                     alu_q;
    logic [`OOO_MUL_LAT-1:0]   mul_v_q;
    pipe_t                     mul_q [`OOO_MUL_LAT];
    pipe_t                     mul_wb;    // last multiply stage
    xlen_t                     src1;
    xlen_t                     src2;
    xlen_t                     alu_res;
    xlen_t                     mul_res;
    logic                      ops_ready;
    logic                      issue;
    logic                      is_mul;

    assign is_mul = (ren_in.op == OP_MUL);

    // addi ignores rs2, so its ready bit does not matter
    assign ops_ready = ready_q[ren_in.prs1] && ((ren_in.op == OP_ADDI) || ready_q[ren_in.prs2]);
    assign ren_ready = !ren_valid || ops_ready;  // empty slot always takes
    assign issue     = ren_valid && ops_ready;

    assign src1 = prf_q[ren_in.prs1];
    assign src2 = (ren_in.op == OP_ADDI) ? ren_in.imm : prf_q[ren_in.prs2];

    always_comb begin
        case (ren_in.op)
            OP_SUB:  alu_res = src1 - src2;
            OP_XOR:  alu_res = src1 ^ src2;
            default: alu_res = src1 + src2;  // add and addi
        endcase
    end

    assign mul_res = src1 * src2;  // low word only
    assign mul_wb  = mul_q[`OOO_MUL_LAT-1];

    // pipe valids
    always_ff @(posedge clk) begin
        if (!rstn) begin
            alu_v_q <= 1'b0;
            mul_v_q <= '0;
        end else begin
            alu_v_q <= issue && !is_mul;
            mul_v_q <= {mul_v_q[`OOO_MUL_LAT-2:0], issue && is_mul};
        end
    end

    // pipe payloads, r0 writers report zero
    always_ff @(posedge clk) begin
        alu_q.wr        <= ren_in.wr;
        alu_q.prd       <= ren_in.prd;
        alu_q.done.tag  <= ren_in.tag;
        alu_q.done.data <= ren_in.wr ? alu_res : '0;
        mul_q[0].wr        <= ren_in.wr;
        mul_q[0].prd       <= ren_in.prd;
        mul_q[0].done.tag  <= ren_in.tag;
        mul_q[0].done.data <= ren_in.wr ? mul_res : '0;
        for (int i = 1; i < `OOO_MUL_LAT; i++) begin
            mul_q[i] <= mul_q[i-1];  // plain shift, product formed at issue
        end
    end

    // prf and ready bits, written in the cycle the completion is reported
    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int i = 0; i < `OOO_PHYS_REGS; i++) begin
                prf_q[i]   <= '0;
                ready_q[i] <= (i < `OOO_ARCH_REGS);  // initial mappings hold zero
            end
        end else begin
            if (issue && ren_in.wr) begin
                ready_q[ren_in.prd] <= 1'b0;  // consumers wait for the result
            end
            if (alu_v_q && alu_q.wr) begin
                prf_q[alu_q.prd]   <= alu_q.done.data;
                ready_q[alu_q.prd] <= 1'b1;
            end
            if (mul_v_q[`OOO_MUL_LAT-1] && mul_wb.wr) begin
                prf_q[mul_wb.prd]   <= mul_wb.done.data;
                ready_q[mul_wb.prd] <= 1'b1;
            end
        end
    end

    assign alu_done_valid = alu_v_q;
    assign alu_done       = alu_q.done;
    assign mul_done_valid = mul_v_q[`OOO_MUL_LAT-1];
    assign mul_done       = mul_wb.done;

    // rename hands out each free register to one writer only
    a_one_writer: assert property (@(posedge clk) disable iff (!rstn)
        (alu_v_q && alu_q.wr && mul_v_q[`OOO_MUL_LAT-1] && mul_wb.wr)
        |-> (alu_q.prd != mul_wb.prd))
        else $error("alu and mul both write phys reg %0d", alu_q.prd);

endmodule

// File: design/reorder_buffer.sv
`include "ooo_macros.svh"

module reorder_buffer import ooo_pkg::*; (
    input  logic          clk,
    input  logic          rstn,
    // allocation from rename
    input  logic          alloc_valid,
    input  rob_alloc_t    alloc,
    output rob_tag_t      rob_tail,
    output logic          rob_full,
    // completions, always accepted
    input  logic          alu_done_valid,
    input  complete_t     alu_done,
    input  logic          mul_done_valid,
    input  complete_t     mul_done,
    // commit stream, two slots
    output logic [1:0]    commit_valid,
    output commit_t [1:0] commit,
    input  logic          commit_ready,
    // old mappings back to the free list
    output free_t [1:0]   free_out
);

    localparam int DEPTH = `OOO_ROB_DEPTH;

    rob_alloc_t             ent_q  [DEPTH];  // static info per entry
    xlen_t                  data_q [DEPTH];  // result, valid once done
    logic [DEPTH-1:0]       busy_q;          // entry allocated
    logic [DEPTH-1:0]       done_q;          // result arrived
    rob_tag_t               head_q;
    rob_tag_t               tail_q;
    logic [$clog2(DEPTH):0] count_q;
    logic [$clog2(DEPTH):0] count_next;
    rob_tag_t               rd_idx [2];      // head and head+1
    logic [1:0]             ret;             // slots retiring this cycle
    commit_t [1:0]          ret_data;

    assign rob_tail = tail_q;
    assign rob_full = (count_q == DEPTH);

    assign rd_idx[0] = head_q;
    assign rd_idx[1] = head_q + 1'b1;  // wraps with the tag width

    // in order, slot 1 only behind slot 0
    assign ret[0] = commit_ready && busy_q[rd_idx[0]] && done_q[rd_idx[0]];
    assign ret[1] = ret[0] && busy_q[rd_idx[1]] && done_q[rd_idx[1]];

    always_comb begin
        for (int k = 0; k < 2; k++) begin
            ret_data[k].pc    = ent_q[rd_idx[k]].pc;
            ret_data[k].rd    = ent_q[rd_idx[k]].rd;
            ret_data[k].data  = data_q[rd_idx[k]];
            ret_data[k].wr    = ent_q[rd_idx[k]].wr;
            free_out[k].valid = ret[k] && ent_q[rd_idx[k]].wr;  // r0 has nothing to free
            free_out[k].preg  = ent_q[rd_idx[k]].old_prd;
        end
    end

    always_comb begin
        count_next = count_q;
        if (alloc_valid) begin
            count_next = count_next + 1'b1;
        end
        if (ret[0]) begin
            count_next = count_next - 1'b1;
        end
        if (ret[1]) begin
            count_next = count_next - 1'b1;
        end
    end

    // pointers, occupancy and entry state
    always_ff @(posedge clk) begin
        if (!rstn) begin
            head_q       <= '0;
            tail_q       <= '0;
            count_q      <= '0;
            busy_q       <= '0;
            done_q       <= '0;
            commit_valid <= 2'b00;
        end else begin
            count_q <= count_next;
            head_q  <= head_q + rob_tag_t'(ret[0]) + rob_tag_t'(ret[1]);
            if (alloc_valid) begin
                busy_q[tail_q] <= 1'b1;
                done_q[tail_q] <= 1'b0;
                tail_q         <= tail_q + 1'b1;
            end
            if (alu_done_valid) begin
                done_q[alu_done.tag] <= 1'b1;
            end
            if (mul_done_valid) begin
                done_q[mul_done.tag] <= 1'b1;
            end
            if (ret[0]) begin
                busy_q[rd_idx[0]] <= 1'b0;
            end
            if (ret[1]) begin
                busy_q[rd_idx[1]] <= 1'b0;
            end
            if (commit_ready) begin
                commit_valid <= ret;  // held while the sink stalls
            end
        end
    end

    // entry payloads and commit slots
    always_ff @(posedge clk) begin
        if (alloc_valid) begin
            ent_q[tail_q] <= alloc;
        end
        if (alu_done_valid) begin
            data_q[alu_done.tag] <= alu_done.data;
        end
        if (mul_done_valid) begin
            data_q[mul_done.tag] <= mul_done.data;
        end
        if (commit_ready) begin
            commit <= ret_data;
        end
    end

    // rename must see rob_full before it allocates
    a_no_alloc_full: assert property (@(posedge clk) disable iff (!rstn)
        alloc_valid |-> !rob_full)
        else $error("rob allocation while full");

    // each completion belongs to a live entry still waiting for it
    a_alu_live: assert property (@(posedge clk) disable iff (!rstn)
        alu_done_valid |-> (busy_q[alu_done.tag] && !done_q[alu_done.tag]))
        else $error("alu completion to idle rob entry %0d", alu_done.tag);

    a_mul_live: assert property (@(posedge clk) disable iff (!rstn)
        mul_done_valid |-> (busy_q[mul_done.tag] && !done_q[mul_done.tag]))
        else $error("mul completion to idle rob entry %0d", mul_done.tag);

endmodule

// File: design/ooo_core_top.sv
module ooo_core_top import ooo_pkg::*; (
    input  logic          clk,
    input  logic          rstn,
    input  logic          in_valid,
    output logic          in_ready,
    input  instr_t        in_instr,
    output logic [1:0]    commit_valid,
    output commit_t [1:0] commit,
    input  logic          commit_ready
);

    logic        ren_valid;
    logic        ren_ready;
    renamed_t    ren;
    logic        alloc_valid;
    rob_alloc_t  alloc;
    rob_tag_t    rob_tail;
    logic        rob_full;
    logic        alu_done_valid;
    complete_t   alu_done;
    logic        mul_done_valid;
    complete_t   mul_done;
    free_t [1:0] free_regs;   // rob -> free list

    // decode, map and allocate
    rename_stage u_rename_stage (
        .clk         (clk),
        .rstn        (rstn),
        .in_valid    (in_valid),
        .in_ready    (in_ready),
        .in_instr    (in_instr),
        .ren_valid   (ren_valid),
        .ren_ready   (ren_ready),
        .ren_out     (ren),
        .alloc_valid (alloc_valid),
        .alloc       (alloc),
        .rob_tail    (rob_tail),
        .rob_full    (rob_full),
        .free_in     (free_regs)
    );

    // prf, in-order issue, alu and mul pipes
    issue_execute u_issue_execute (
        .clk            (clk),
        .rstn           (rstn),
        .ren_valid      (ren_valid),
        .ren_ready      (ren_ready),
        .ren_in         (ren),
        .alu_done_valid (alu_done_valid),
        .alu_done       (alu_done),
        .mul_done_valid (mul_done_valid),
        .mul_done       (mul_done)
    );

    // in-order retirement
    reorder_buffer u_reorder_buffer (
        .clk            (clk),
        .rstn           (rstn),
        .alloc_valid    (alloc_valid),
        .alloc          (alloc),
        .rob_tail       (rob_tail),
        .rob_full       (rob_full),
        .alu_done_valid (alu_done_valid),
        .alu_done       (alu_done),
        .mul_done_valid (mul_done_valid),
        .mul_done       (mul_done),
        .commit_valid   (commit_valid),
        .commit         (commit),
        .commit_ready   (commit_ready),
        .free_out       (free_regs)
    );

endmodule

// File: bench/ooo_core_tb.sv
`include "ooo_macros.svh"

module ooo_core_tb import ooo_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int N_INSTR    = 200;
    localparam int MAX_CYCLES = N_INSTR * 12 + 100;  // worst case per instruction plus margin
    localparam int STALL_AT   = 50;                  // accepted count that opens the long stall
    localparam int STALL_LEN  = 40;

    logic          clk          = 1'b0;
    logic          rstn         = 1'b0;
    logic          in_valid     = 1'b0;
    logic          in_ready;
    instr_t        in_instr     = '0;
    logic [1:0]    commit_valid;
    commit_t [1:0] commit;
    logic          commit_ready = 1'b1;

    instr_t        prog [N_INSTR];
    xlen_t         arch_regs [`OOO_ARCH_REGS];  // architectural model where r0 is never written
    commit_t       exp_q [$];                   // expected commits in program order
    logic [31:0]   rng_state    = 32'd98;
    int            n_sent       = 0;
    int            n_commit     = 0;
    int            mismatch_cnt = 0;
    int            other_cnt    = 0;
    int            cycle_cnt    = 0;
    logic          stall_active = 1'b0;  // long commit stall in progress
    logic          saw_drop     = 1'b0;  // in_ready went low inside it
    logic          rstn_d       = 1'b0;  // values seen at the previous negedge
    logic          ready_d      = 1'b1;
    logic [1:0]    valid_d      = 2'b00;
    commit_t [1:0] commit_d;

    ooo_core_top u_ooo_core_top (
        .clk          (clk),
        .rstn         (rstn),
        .in_valid     (in_valid),
        .in_ready     (in_ready),
        .in_instr     (in_instr),
        .commit_valid (commit_valid),
        .commit       (commit),
        .commit_ready (commit_ready)
    );

    initial begin
        forever #5 clk = ~clk;
    end

    // xorshift32
    function automatic logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    // one third mul with rs1 often chained to the previous rd
    task automatic build_program();
        logic [31:0] r;
        arch_reg_t   prev_rd;
        prev_rd = '0;
        for (int i = 0; i < N_INSTR; i++) begin
            r = next_rand();
            case (r % 6)
                0, 1:    prog[i].op = OP_MUL;
                2:       prog[i].op = OP_ADD;
                3:       prog[i].op = OP_SUB;
                4:       prog[i].op = OP_XOR;
                default: prog[i].op = OP_ADDI;
            endcase
            prog[i].pc  = 32'h0000_1000 + 32'(4 * i);
            prog[i].rd  = r[10:8];
            prog[i].rs1 = r[16] ? prev_rd : r[13:11];  // raw chains such as mul then alu
            prog[i].rs2 = r[19:17];
            prog[i].imm = next_rand();
            prev_rd     = prog[i].rd;
        end
    endtask

    // result of one instruction on architectural operands
    function automatic xlen_t expected_result(input instr_t ins, input xlen_t a, input xlen_t b);
        case (ins.op)
            OP_ADD:  return a + b;
            OP_SUB:  return a - b;
            OP_XOR:  return a ^ b;
            OP_ADDI: return a + ins.imm;
            OP_MUL:  return a * b;  // low word kept
            default: return '0;
        endcase
    endfunction

    // run an accepted instruction on the model and queue its commit
    task automatic record_accept(input instr_t ins);
        commit_t e;
        xlen_t   res;
        res    = expected_result(ins, arch_regs[ins.rs1], arch_regs[ins.rs2]);
        e.pc   = ins.pc;
        e.rd   = ins.rd;
        e.wr   = (ins.rd != '0);
        e.data = e.wr ? res : '0;  // r0 writers report zero
        if (e.wr) begin
            arch_regs[ins.rd] = res;
        end
        exp_q.push_back(e);
    endtask

    task automatic check_commit(input commit_t got);
        commit_t e;
        if (exp_q.size() == 0) begin
            $display("unexpected commit at pc %h, no accepted instruction left", got.pc);
            other_cnt++;
            return;
        end
        e = exp_q.pop_front();
        n_commit++;
        if (got.pc !== e.pc || got.rd !== e.rd || got.data !== e.data || got.wr !== e.wr) begin
            $display("Mismatch commit: pc %h rd %h data %h wr %h, expected %h %h %h %h",
                     got.pc, got.rd, got.data, got.wr, e.pc, e.rd, e.data, e.wr);
            mismatch_cnt++;
        end
    endtask

    // stimulus, model updates and commit_ready
    initial begin
        int stall_left;
        bit stall_done;
        stall_left = 0;
        stall_done = 1'b0;
        for (int i = 0; i < `OOO_ARCH_REGS; i++) begin
            arch_regs[i] = '0;
        end
        build_program();
        repeat (8) @(posedge clk);
        rstn <= 1'b1;
        while (n_commit < N_INSTR) begin
            @(posedge clk);
            if (in_valid && in_ready) begin  // transfer on this edge
                record_accept(in_instr);
                n_sent++;
            end
            if (n_sent < N_INSTR) begin
                in_valid <= 1'b1;
                in_instr <= prog[n_sent];  // held until taken
            end else begin
                in_valid <= 1'b0;
            end
            if (!stall_done && n_sent >= STALL_AT) begin
                stall_done = 1'b1;
                stall_left = STALL_LEN;
            end
            stall_active = (stall_left > 0);
            if (stall_left > 0) begin
                commit_ready <= 1'b0;
                stall_left--;
            end else if (n_sent >= N_INSTR / 2) begin
                commit_ready <= ((next_rand() % 10) >= 3);  // low about 30 %
            end else begin
                commit_ready <= 1'b1;
            end
        end
        commit_ready <= 1'b1;
        repeat (10) @(posedge clk);  // room for a duplicate commit to show
        if (!saw_drop) begin
            $display("in_ready never dropped during the long commit stall");
            other_cnt++;
        end
        $display("commits checked %0d, mismatches %0d, other errors %0d",
                 n_commit, mismatch_cnt, other_cnt);
        if (mismatch_cnt == 0 && other_cnt == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    // outputs sampled mid-cycle
    always @(negedge clk) begin
        if (!rstn || !rstn_d) begin
            if (in_ready !== 1'b0 || commit_valid !== 2'b00) begin
                $display("in_ready or commit_valid not low during or right after reset");
                other_cnt++;
            end
        end else begin
            if (commit_valid == 2'b10) begin
                $display("commit slot 1 valid without slot 0 at pc %h", commit[1].pc);
                other_cnt++;
            end
            if (!ready_d) begin  // sink stalled at the last edge so slots must hold
                if (commit_valid !== valid_d) begin
                    $display("Mismatch commit_valid while stalled: got %h expected %h",
                             commit_valid, valid_d);
                    mismatch_cnt++;
                end
                for (int k = 0; k < 2; k++) begin
                    if (valid_d[k] && commit[k] !== commit_d[k]) begin
                        $display("Mismatch commit[%0d] held: pc %h data %h, expected %h %h",
                                 k, commit[k].pc, commit[k].data, commit_d[k].pc,
                                 commit_d[k].data);
                        mismatch_cnt++;
                    end
                end
            end
            if (commit_ready) begin  // taken at the next edge with slot 0 first
                for (int k = 0; k < 2; k++) begin
                    if (commit_valid[k]) begin
                        check_commit(commit[k]);
                    end
                end
            end
            if (stall_active && !in_ready) begin
                saw_drop = 1'b1;
            end
        end
        rstn_d   = rstn;
        ready_d  = commit_ready;
        valid_d  = commit_valid;
        commit_d = commit;
    end

    initial begin
        while (cycle_cnt < MAX_CYCLES) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("timeout after %0d cycles, %0d of %0d instructions committed",
                 cycle_cnt, n_commit, N_INSTR);
        $display("commits checked %0d, mismatches %0d, other errors %0d",
                 n_commit, mismatch_cnt, other_cnt + 1);
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

// File: sources.f
+incdir+design
design/ooo_pkg.sv
design/rename_stage.sv
design/issue_execute.sv
design/reorder_buffer.sv
design/ooo_core_top.sv
bench/ooo_core_tb.sv

// File: Bender.yml
package:
  name: ooo_core

sources:
  - include_dirs:
      - design
    files:
      - design/ooo_pkg.sv
      - design/rename_stage.sv
      - design/issue_execute.sv
      - design/reorder_buffer.sv
      - design/ooo_core_top.sv
  - target: test
    include_dirs:
      - design
    files:
      - bench/ooo_core_tb.sv
